// ==== rtl/cfu_defines.svh ====
// sizes and function codes shared by the whole dot-product unit
// memories A and B must share one address width, which also bounds K
// function codes travel in funct7; funct3 is ignored
`ifndef CFU_DEFINES_SVH
`define CFU_DEFINES_SVH

// operand memory address widths
`define CFU_A_ADDR_BITS 10
`define CFU_B_ADDR_BITS 10

// row geometry
`define CFU_LANES 4
`define CFU_LANE_BITS 8
`define CFU_ACC_BITS 32

// funct7 values
`define CFU_FN_WRITE_A 7'd0
`define CFU_FN_WRITE_B 7'd1
`define CFU_FN_COMPUTE 7'd2
`define CFU_FN_READ 7'd3

`endif

// ==== rtl/cfu_pkg.sv ====
// types for the dot-product unit
// lane 0 always sits in the most significant slot of a packed vector
// all arithmetic is two's complement and wraps at the accumulator width
`include "cfu_defines.svh"

package cfu_pkg;

  // one host command as presented on the command port
  typedef struct packed {
    logic [6:0]  funct7;
    logic [2:0]  funct3;
    logic [31:0] in0;
    logic [31:0] in1;
  } cmd_t;

  // single int8 operand
  typedef logic signed [`CFU_LANE_BITS-1:0] lane_t;

  // packed word of memory B, index 0 is bits 31:24
  typedef lane_t [0:`CFU_LANES-1] lane_vec_t;

  typedef logic signed [`CFU_ACC_BITS-1:0] acc_t;

  // all lane results, lane 0 in the top 32 bits
  typedef acc_t [0:`CFU_LANES-1] acc_vec_t;

  // one beat into the MAC row
  typedef struct packed {
    logic      valid;
    lane_t     a;
    lane_vec_t b;
  } feed_t;

endpackage

// ==== rtl/operand_buffer.sv ====
// single-port operand memory, one access per cycle
// read data is registered and shows up one cycle after the address
// the read register holds its value on write cycles
module operand_buffer #(
  parameter int ADDR_BITS = 10,
  parameter type data_t = logic [7:0]
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wr_en,
  input  logic [ADDR_BITS-1:0] addr,
  input  data_t                wr_data,
  output data_t                rd_data
);

  localparam int DEPTH = 2 ** ADDR_BITS;

  data_t mem [DEPTH];

  // storage array
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[addr] <= wr_data;
    end
  end

  // read port register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (!wr_en) begin
      rd_data <= mem[addr];
    end
  end

endmodule

// ==== rtl/cfu_sequencer.sv ====
// command decode and operand streaming for the dot-product unit
// one command in flight; cmd_ready is high only in idle
// compute latency is K + 1 + CFU_LANES cycles after the clear cycle
// K comes from in0 and is limited by the memory address width
`include "cfu_defines.svh"

module cfu_sequencer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cmd_valid,
  output logic                        cmd_ready,
  input  cfu_pkg::cmd_t               cmd,
  output logic                        rsp_valid,
  input  logic                        rsp_ready,
  output logic [31:0]                 rsp_data,
  output logic                        a_wr_en,
  output logic [`CFU_A_ADDR_BITS-1:0] a_addr,
  output cfu_pkg::lane_t              a_wr_data,
  input  cfu_pkg::lane_t              a_rd_data,
  output logic                        b_wr_en,
  output logic [`CFU_B_ADDR_BITS-1:0] b_addr,
  output cfu_pkg::lane_vec_t          b_wr_data,
  input  cfu_pkg::lane_vec_t          b_rd_data,
  output cfu_pkg::feed_t              feed,
  output logic                        clear,
  input  cfu_pkg::acc_vec_t           acc
);

  localparam int CNT_BITS = `CFU_A_ADDR_BITS;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WRITE,
    S_CLEAR,
    S_STREAM,
    S_DRAIN,
    S_RESPOND
  } state_t;

  state_t              state;
  state_t              state_nxt;
  cfu_pkg::cmd_t       cmd_q;
  logic [CNT_BITS-1:0] cnt;
  logic [CNT_BITS-1:0] k_len;
  logic                accept;
  logic                strobe;
  logic                feed_vld;
  logic                last_beat;
  logic                drain_done;

  assign cmd_ready  = (state == S_IDLE);
  assign accept     = cmd_valid && cmd_ready;
  assign k_len      = cmd_q.in0[CNT_BITS-1:0];
  assign strobe     = (state == S_STREAM);
  assign last_beat  = (cnt == k_len - 1'b1);
  // drain covers the read latency plus the skew of the row
  assign drain_done = (cnt == CNT_BITS'(`CFU_LANES));

  // captured command, held until the response is taken
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (accept) begin
          state_nxt = (cmd.funct7 == `CFU_FN_COMPUTE) ? S_CLEAR : S_WRITE;
        end
      end
      S_WRITE:   state_nxt = S_RESPOND;
      // K of zero skips straight to the drain
      S_CLEAR:   state_nxt = (k_len == '0) ? S_DRAIN : S_STREAM;
      S_STREAM:  if (last_beat) state_nxt = S_DRAIN;
      S_DRAIN:   if (drain_done) state_nxt = S_RESPOND;
      S_RESPOND: if (rsp_ready) state_nxt = S_IDLE;
      default:   state_nxt = S_IDLE;
    endcase
  end

  // address counter in stream, cycle counter in drain
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (strobe) begin
      cnt <= last_beat ? '0 : cnt + 1'b1;
    end else if (state == S_DRAIN) begin
      cnt <= cnt + 1'b1;
    end else begin
      cnt <= '0;
    end
  end

  // valid follows the address by the memory read latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feed_vld <= 1'b0;
    end else begin
      feed_vld <= strobe;
    end
  end

  // memory side
  assign a_wr_en   = (state == S_WRITE) && (cmd_q.funct7 == `CFU_FN_WRITE_A);
  assign b_wr_en   = (state == S_WRITE) && (cmd_q.funct7 == `CFU_FN_WRITE_B);
  assign a_addr    = strobe ? `CFU_A_ADDR_BITS'(cnt) : cmd_q.in0[`CFU_A_ADDR_BITS-1:0];
  assign b_addr    = strobe ? `CFU_B_ADDR_BITS'(cnt) : cmd_q.in0[`CFU_B_ADDR_BITS-1:0];
  assign a_wr_data = cmd_q.in1[31:24];
  assign b_wr_data = cfu_pkg::lane_vec_t'(cmd_q.in1);

  always_comb begin
    feed.valid = feed_vld;
    feed.a     = a_rd_data;
    feed.b     = b_rd_data;
  end

  assign clear     = (state == S_CLEAR);
  assign rsp_valid = (state == S_RESPOND);

  // only reads return data, everything else answers zero
  always_comb begin
    rsp_data = '0;
    if (cmd_q.funct7 == `CFU_FN_READ) begin
      rsp_data = acc[cmd_q.in1[1:0]];
    end
  end

endmodule

// ==== rtl/mac_row.sv ====
// one row of multiply-accumulate cells fed from the west
// a beat reaches cell j after j cycles; B lane j is skewed to match
// accumulators wrap at CFU_ACC_BITS and only clear on the clear input
`include "cfu_defines.svh"

module mac_row (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear,
  input  cfu_pkg::feed_t    feed,
  output cfu_pkg::acc_vec_t acc
);

  localparam int LANES = `CFU_LANES;
  localparam int PROD_BITS = 2 * `CFU_LANE_BITS;

  // A operand and valid bit heading east, index j feeds cell j
  cfu_pkg::lane_t   a_pipe [1:LANES-1];
  logic [LANES-1:1] v_pipe;

  always_ff @(posedge clk) begin
    a_pipe[1] <= feed.a;
    for (int i = 2; i < LANES; i++) begin
      a_pipe[i] <= a_pipe[i-1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v_pipe <= '0;
    end else begin
      v_pipe[1] <= feed.valid;
      for (int i = 2; i < LANES; i++) begin
        v_pipe[i] <= v_pipe[i-1];
      end
    end
  end

  for (genvar j = 0; j < LANES; j++) begin : g_cell
    cfu_pkg::lane_t              a_in;
    cfu_pkg::lane_t              b_in;
    logic                        v_in;
    logic signed [PROD_BITS-1:0] prod;
    cfu_pkg::acc_t               acc_q;

    if (j == 0) begin : g_head
      // first cell takes the beat straight from the input
      assign a_in = feed.a;
      assign v_in = feed.valid;
      assign b_in = feed.b[0];
    end else begin : g_tail
      // j stages of delay on this B lane
      cfu_pkg::lane_t b_dly [1:j];

      always_ff @(posedge clk) begin
        b_dly[1] <= feed.b[j];
        for (int i = 2; i <= j; i++) begin
          b_dly[i] <= b_dly[i-1];
        end
      end

      assign a_in = a_pipe[j];
      assign v_in = v_pipe[j];
      assign b_in = b_dly[j];
    end

    assign prod = $signed(a_in) * $signed(b_in);

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        acc_q <= '0;
      end else if (clear) begin
        acc_q <= '0;
      end else if (v_in) begin
        acc_q <= acc_q + prod;
      end
    end

    assign acc[j] = acc_q;
  end

endmodule

// ==== rtl/cfu_dot_top.sv ====
// top level of the four-lane int8 dot-product unit
// host side is a command and a response valid/ready pair
// memory A holds int8 values, memory B holds four int8 lanes per word
`include "cfu_defines.svh"

module cfu_dot_top (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          cmd_valid,
  output logic          cmd_ready,
  input  cfu_pkg::cmd_t cmd,
  output logic          rsp_valid,
  input  logic          rsp_ready,
  output logic [31:0]   rsp_data
);

  logic                        a_wr_en;
  logic [`CFU_A_ADDR_BITS-1:0] a_addr;
  cfu_pkg::lane_t              a_wr_data;
  cfu_pkg::lane_t              a_rd_data;
  logic                        b_wr_en;
  logic [`CFU_B_ADDR_BITS-1:0] b_addr;
  cfu_pkg::lane_vec_t          b_wr_data;
  cfu_pkg::lane_vec_t          b_rd_data;
  cfu_pkg::feed_t              feed;
  logic                        clear;
  cfu_pkg::acc_vec_t           acc;

  cfu_sequencer u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data),
    .a_wr_en   (a_wr_en),
    .a_addr    (a_addr),
    .a_wr_data (a_wr_data),
    .a_rd_data (a_rd_data),
    .b_wr_en   (b_wr_en),
    .b_addr    (b_addr),
    .b_wr_data (b_wr_data),
    .b_rd_data (b_rd_data),
    .feed      (feed),
    .clear     (clear),
    .acc       (acc)
  );

  // int8 vector
  operand_buffer #(
    .ADDR_BITS (`CFU_A_ADDR_BITS),
    .data_t    (cfu_pkg::lane_t)
  ) buf_a (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (a_wr_en),
    .addr    (a_addr),
    .wr_data (a_wr_data),
    .rd_data (a_rd_data)
  );

  // packed four-lane words
  operand_buffer #(
    .ADDR_BITS (`CFU_B_ADDR_BITS),
    .data_t    (cfu_pkg::lane_vec_t)
  ) buf_b (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (b_wr_en),
    .addr    (b_addr),
    .wr_data (b_wr_data),
    .rd_data (b_rd_data)
  );

  mac_row u_row (
    .clk   (clk),
    .rst_n (rst_n),
    .clear (clear),
    .feed  (feed),
    .acc   (acc)
  );

endmodule

// ==== sim/cfu_checker.sv ====
// passive checker on the host ports of the dot-product unit
// the expected response travels with each accepted command, in issue order
// counts settle one clock after the edge that produced them
module cfu_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_valid,
  input  logic        cmd_ready,
  input  logic [31:0] exp_data,
  input  logic        rsp_valid,
  input  logic        rsp_ready,
  input  logic [31:0] rsp_data,
  output int          err_count,
  output int          rsp_count
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] exp_q [$];

  initial begin
    err_count = 0;
    rsp_count = 0;
  end

  always @(posedge clk) begin
    int errs;
    errs = 0;
    if (rst_n) begin
      if (cmd_valid && cmd_ready) begin
        exp_q.push_back(exp_data);
      end
      // a pending response must keep the command port closed
      if (rsp_valid && cmd_ready) begin
        $display("command port open at %0t ns while a response is pending", $time);
        errs++;
      end
      if (rsp_valid) begin
        if (exp_q.size() == 0) begin
          $display("response at %0t ns without any command waiting for it", $time);
          errs++;
        end else begin
          // data must hold its value through every stalled cycle
          if (rsp_data !== exp_q[0]) begin
            $display("ERROR at %0t ns: rsp_data expected 0x%08h, actual 0x%08h",
                     $time, exp_q[0], rsp_data);
            errs++;
          end
          if (rsp_ready) begin
            void'(exp_q.pop_front());
            rsp_count <= rsp_count + 1;
          end
        end
      end
    end
    err_count <= err_count + errs;
  end

endmodule

// ==== sim/tb_cfu_dot.sv ====
// testbench for the four-lane int8 dot-product unit
// operands, K and response stalls come from a 16-bit Fibonacci LFSR
// the model keeps its own copy of both memories and predicts every response
// commands go out one at a time and each waits for its response
`include "cfu_defines.svh"

module tb_cfu_dot;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 1000;

  logic          clk;
  logic          rst_n;
  logic          cmd_valid;
  logic          cmd_ready;
  cfu_pkg::cmd_t cmd;
  logic          rsp_valid;
  logic          rsp_ready;
  logic [31:0]   rsp_data;
  logic [31:0]   exp_data;
  int            err_count;
  int            rsp_count;

  logic [15:0] lfsr;
  logic        stall_en;
  bit          aborted;
  int          timeouts;
  int          tests_run;
  int          tests_failed;
  int          start_errs;
  int          k;
  int          i;
  int          j;

  // model copies of both memories and the four lane sums
  logic signed [7:0]  mem_a [2**`CFU_A_ADDR_BITS];
  logic [31:0]        mem_b [2**`CFU_B_ADDR_BITS];
  logic signed [31:0] model_acc [4];

  cfu_dot_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data)
  );

  cfu_checker chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .exp_data  (exp_data),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data),
    .err_count (err_count),
    .rsp_count (rsp_count)
  );

  always #5 clk = ~clk;

  // taps 16 14 13 11, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          b;
    r = '0;
    for (b = 0; b < n; b++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [7:0] extreme_value();
    return rand_bits(1) ? 8'h7f : 8'h80;
  endfunction

  // issue one command, then wait until its response is taken
  task automatic send(input logic [6:0] fn, input logic [31:0] in0, input logic [31:0] in1,
                      input logic [31:0] exp_val, input string what);
    cfu_pkg::cmd_t c;
    bit            done;
    int            n;
    if (!aborted) begin
      c.funct7 = fn;
      c.funct3 = 3'(rand_bits(3));
      c.in0    = in0;
      c.in1    = in1;
      cmd_valid <= 1'b1;
      cmd       <= c;
      exp_data  <= exp_val;
      if (!stall_en) begin
        rsp_ready <= 1'b1;
      end
      done = 1'b0;
      for (n = 0; n < TIMEOUT && !done; n++) begin
        @(posedge clk);
        done = cmd_ready;
      end
      cmd_valid <= 1'b0;
      if (!done) begin
        $display("timeout: %s was never accepted", what);
        timeouts++;
        aborted = 1'b1;
      end else begin
        done = 1'b0;
        for (n = 0; n < TIMEOUT && !done; n++) begin
          @(posedge clk);
          done = rsp_valid && rsp_ready;
          if (!done && stall_en) begin
            rsp_ready <= 1'(rand_bits(1));
          end
        end
        if (!done) begin
          $display("timeout: no response to %s", what);
          timeouts++;
          aborted = 1'b1;
        end
      end
    end
  endtask

  task automatic write_a(input int addr, input logic [7:0] v);
    mem_a[addr] = v;
    send(`CFU_FN_WRITE_A, 32'(addr), {v, 24'(rand_bits(24))}, 32'd0, "write A");
  endtask

  task automatic write_b(input int addr, input logic [31:0] w);
    mem_b[addr] = w;
    send(`CFU_FN_WRITE_B, 32'(addr), w, 32'd0, "write B");
  endtask

  task automatic load_random(input int len);
    int a;
    for (a = 0; a < len; a++) begin
      write_a(a, 8'(rand_bits(8)));
      write_b(a, rand_bits(32));
    end
  endtask

  // lane j sums A[k] times byte j of B[k], lane 0 in bits 31:24
  task automatic compute(input int len);
    logic signed [15:0] p;
    int                 a;
    int                 l;
    for (l = 0; l < 4; l++) begin
      model_acc[l] = '0;
      for (a = 0; a < len; a++) begin
        p = $signed(mem_a[a]) * $signed(mem_b[a][31-8*l -: 8]);
        model_acc[l] = model_acc[l] + p;
      end
    end
    send(`CFU_FN_COMPUTE, 32'(len), rand_bits(32), 32'd0, "compute");
  endtask

  task automatic read_lane(input int l);
    send(`CFU_FN_READ, rand_bits(32), {30'(rand_bits(30)), 2'(l)}, model_acc[l],
         $sformatf("read of lane %0d", l));
  endtask

  task automatic begin_test();
    start_errs = err_count;
  endtask

  task automatic end_test(input string name);
    // checker counts land one edge later
    @(posedge clk);
    tests_run++;
    if (aborted) begin
      $display("test %s: not finished", name);
      tests_failed++;
    end else if (err_count != start_errs) begin
      $display("test %s: FAILED", name);
      tests_failed++;
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    cmd_valid    = 1'b0;
    cmd          = '0;
    rsp_ready    = 1'b1;
    exp_data     = '0;
    lfsr         = 16'd48934;
    stall_en     = 1'b0;
    aborted      = 1'b0;
    timeouts     = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    begin_test();
    k = 1 + rand_bits(6);
    load_random(k);
    compute(k);
    read_lane(0);
    end_test("dot_product");

    begin_test();
    k = 1 + rand_bits(6);
    load_random(k);
    compute(k);
    for (j = 0; j < 4; j++) begin
      read_lane(j);
    end
    end_test("lane_select");

    // sums of +-16384 terms well past 16 bits
    begin_test();
    k = 300;
    for (i = 0; i < k; i++) begin
      write_a(i, extreme_value());
      write_b(i, {extreme_value(), extreme_value(), extreme_value(), extreme_value()});
    end
    compute(k);
    for (j = 0; j < 4; j++) begin
      read_lane(j);
    end
    end_test("signed_extremes");

    begin_test();
    stall_en = 1'b1;
    k = 1 + rand_bits(6);
    load_random(k);
    compute(k);
    for (j = 0; j < 4; j++) begin
      read_lane(j);
    end
    stall_en = 1'b0;
    end_test("back_pressure");

    // fresh data, the old sums must be gone
    begin_test();
    k = 1 + rand_bits(5);
    load_random(k);
    compute(k);
    for (j = 0; j < 4; j++) begin
      read_lane(j);
    end
    send(7'd9, rand_bits(32), rand_bits(32), 32'd0, "unknown function");
    compute(0);
    read_lane(1);
    end_test("acc_clear");

    $display("tests run %0d, failed %0d, responses %0d, errors %0d, timeouts %0d",
             tests_run, tests_failed, rsp_count, err_count, timeouts);
    if (tests_failed == 0 && err_count == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== cfu_dot.f ====
+incdir+rtl
rtl/cfu_pkg.sv
rtl/operand_buffer.sv
rtl/cfu_sequencer.sv
rtl/mac_row.sv
rtl/cfu_dot_top.sv
sim/cfu_checker.sv
sim/tb_cfu_dot.sv

// ==== Makefile ====
# Verilator build and run of the dot-product unit testbench

TOP := tb_cfu_dot
BIN := obj_dir/V$(TOP)

$(BIN): cfu_dot.f $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)
	verilator --binary --timing -Wno-fatal -f cfu_dot.f --top-module $(TOP)

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
